// File: common/read_master_params.svh
// sizes for the memory-to-stream read master
// RM_MAX_BURST must be a power of two and RM_FIFO_DEPTH at least four times it
`ifndef READ_MASTER_PARAMS_SVH
`define READ_MASTER_PARAMS_SVH

`define RM_ADDR_W 32          // byte address width of the read port
`define RM_DATA_W 32          // width of one memory word
`define RM_BYTES 4            // bytes per word
`define RM_BYTES_LOG2 2
`define RM_SYMBOL_W 8         // one stream symbol is a byte

// length is in bytes so this bounds a single command to just under 1 MiB
`define RM_LEN_W 20

`define RM_MAX_BURST 4        // longest burst in words
`define RM_BURST_W 3          // log2(RM_MAX_BURST) + 1 so the full count fits

`define RM_FIFO_DEPTH 16
`define RM_FIFO_DEPTH_LOG2 4

`endif

// File: common/read_master_pkg.sv
// types shared by the read master blocks and the testbench
// widths come from the params header
package read_master_pkg;

  `include "read_master_params.svh"

  // one transfer request, address word aligned and length a nonzero multiple of RM_BYTES
  typedef struct packed {
    logic [`RM_ADDR_W-1:0] address;   // first byte address
    logic [`RM_LEN_W-1:0]  length;    // bytes to read
    logic                  generate_sop;
    logic                  generate_eop;
  } descriptor_t;

  // status handed back once every read of a command has returned
  typedef struct packed {
    logic done;
    logic stopped;   // stop was being honoured when the command finished
  } response_t;

  // what the FIFO keeps per returned word
  typedef struct packed {
    logic [`RM_DATA_W-1:0] data;   // still in memory byte order here
    logic                  sop;
    logic                  eop;
  } fifo_entry_t;

  // request side of the read port
  typedef enum logic [1:0] {
    issue_idle,         // nothing loaded since reset
    issue_requesting,   // mem_read is up with a burst held on the port
    issue_paused,       // throttled or stopped between bursts
    issue_posted        // whole length has been requested
  } issue_state_e;

endpackage

// File: hw/read_issue.sv
// expects a word-aligned start address and a nonzero whole-word length
// bursts wrap back to RM_MAX_BURST alignment and never cross that boundary
`include "read_master_params.svh"

module read_issue (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  logic [`RM_ADDR_W-1:0]  start_address,
  input  logic [`RM_LEN_W-1:0]   length,
  input  logic                   throttle,
  input  logic                   stop,
  input  logic                   mem_waitrequest,
  output logic [`RM_ADDR_W-1:0]  mem_address,
  output logic                   mem_read,
  output logic [`RM_BURST_W-1:0] mem_burstcount,
  output logic                   read_accepted,
  output logic                   issue_done,
  output logic                   stopped
);

  read_master_pkg::issue_state_e state;
  logic [`RM_ADDR_W-1:0]  address_counter;   // byte address of the next burst
  logic [`RM_LEN_W-1:0]   length_counter;    // bytes not yet requested
  logic [`RM_LEN_W-1:0]   words_left;
  logic [`RM_BURST_W-1:0] words_to_boundary;
  logic [`RM_LEN_W-1:0]   burst_bytes;
  logic                   last_burst;
  logic                   hold_off;

  assign words_left = length_counter >> `RM_BYTES_LOG2;

  // word offset inside the aligned burst window tells how far the boundary is
  assign words_to_boundary = `RM_BURST_W'(`RM_MAX_BURST)
      - {1'b0, address_counter[`RM_BYTES_LOG2 +: `RM_BURST_W-1]};

  // a short tail or an unaligned start both shrink the burst
  assign mem_burstcount = (words_left < `RM_LEN_W'(words_to_boundary)) ?
      words_left[`RM_BURST_W-1:0] : words_to_boundary;

  assign burst_bytes = `RM_LEN_W'({mem_burstcount, {`RM_BYTES_LOG2{1'b0}}});
  assign last_burst  = (length_counter == burst_bytes);   // this burst finishes the command
  assign hold_off    = throttle | stop;

  assign mem_read      = (state == read_master_pkg::issue_requesting);
  assign mem_address   = address_counter;   // counters only move on acceptance so the port holds
  assign read_accepted = mem_read & ~mem_waitrequest;
  assign issue_done    = (state == read_master_pkg::issue_posted);

  // stop only counts once no burst is held on the port
  assign stopped = stop & (state != read_master_pkg::issue_requesting);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= read_master_pkg::issue_idle;
    end
    else
    begin
      case (state)
        read_master_pkg::issue_idle,
        read_master_pkg::issue_posted:
        begin
          // a new command only arrives here since the top waits for the response pop
          if (go)
          begin
            state <= hold_off ? read_master_pkg::issue_paused : read_master_pkg::issue_requesting;
          end
        end
        read_master_pkg::issue_requesting:
        begin
          if (read_accepted)
          begin
            if (last_burst)
              state <= read_master_pkg::issue_posted;
            else if (hold_off)
              state <= read_master_pkg::issue_paused;   // let go of mem_read between bursts
          end
        end
        read_master_pkg::issue_paused:
        begin
          if (!hold_off)
            state <= read_master_pkg::issue_requesting;
        end
        default:
        begin
          state <= read_master_pkg::issue_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      address_counter <= '0;
      length_counter  <= '0;
    end
    else if (go)
    begin
      address_counter <= start_address;
      length_counter  <= length;
    end
    else if (read_accepted)
    begin
      address_counter <= address_counter + `RM_ADDR_W'(burst_bytes);
      length_counter  <= length_counter - burst_bytes;   // reaches zero on the last burst
    end
  end

endmodule

// File: hw/pending_reads.sv
// relies on the memory returning words in request order, one per readdatavalid
// throttle leaves two maximum bursts of room because a held burst still gets accepted
`include "read_master_params.svh"

module pending_reads (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          go,
  input  logic                          read_accepted,
  input  logic [`RM_BURST_W-1:0]        mem_burstcount,
  input  logic                          mem_readdatavalid,
  input  logic [`RM_FIFO_DEPTH_LOG2:0]  fifo_used,
  input  logic                          issue_done,
  output logic                          first_word,
  output logic                          last_word,
  output logic                          throttle,
  output logic                          all_returned
);

  localparam int unsigned throttle_level = `RM_FIFO_DEPTH - 2 * `RM_MAX_BURST;

  logic [`RM_FIFO_DEPTH_LOG2:0]             outstanding;      // words requested and not yet back
  logic [`RM_FIFO_DEPTH_LOG2:0]             burst_ext;
  logic [`RM_LEN_W-`RM_BYTES_LOG2-1:0]      returned_count;   // words back for this command
  logic [`RM_FIFO_DEPTH_LOG2+1:0]           in_flight;
  logic                                     finished;
  logic                                     finished_d1;

  assign burst_ext = {{(`RM_FIFO_DEPTH_LOG2 + 1 - `RM_BURST_W){1'b0}}, mem_burstcount};

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      outstanding <= '0;
    else
    begin
      case ({mem_readdatavalid, read_accepted})
        2'b01:   outstanding <= outstanding + burst_ext;
        2'b10:   outstanding <= outstanding - 1'b1;
        2'b11:   outstanding <= outstanding + burst_ext - 1'b1;   // new burst while a word lands
        default: outstanding <= outstanding;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      returned_count <= '0;
    else if (go)
      returned_count <= '0;
    else if (mem_readdatavalid)
      returned_count <= returned_count + 1'b1;
  end

  // FIFO words plus words still on their way must leave room for the held burst
  assign in_flight = {1'b0, fifo_used} + {1'b0, outstanding};
  assign throttle  = (in_flight > throttle_level);

  assign first_word = mem_readdatavalid & (returned_count == '0);
  // issue_done rises only after the last acceptance so the final word is the lone one left
  assign last_word  = mem_readdatavalid & issue_done & (outstanding == 1);

  assign finished = issue_done & (outstanding == '0);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      finished_d1 <= 1'b0;
    else
      finished_d1 <= finished;
  end

  assign all_returned = finished & ~finished_d1;   // one pulse per command

endmodule

// File: hw/stream_fifo.sv
// show-ahead FIFO with no full check, the caller must never write past RM_FIFO_DEPTH
// output symbols are reversed so the lowest memory byte leaves in the top symbol
`include "read_master_params.svh"

module stream_fifo (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              write,
  input  read_master_pkg::fifo_entry_t      write_entry,
  input  logic                              read,
  output logic [`RM_DATA_W-1:0]             src_data,
  output logic                              src_sop,
  output logic                              src_eop,
  output logic                              src_valid,
  output logic [`RM_FIFO_DEPTH_LOG2:0]      used
);

  localparam int symbols = `RM_DATA_W / `RM_SYMBOL_W;

  read_master_pkg::fifo_entry_t       entries [`RM_FIFO_DEPTH];
  read_master_pkg::fifo_entry_t       head;
  logic [`RM_FIFO_DEPTH_LOG2-1:0]     write_ptr;
  logic [`RM_FIFO_DEPTH_LOG2-1:0]     read_ptr;
  logic                               pop;

  assign head      = entries[read_ptr];   // oldest entry is always on the outputs
  assign src_valid = (used != '0);
  assign pop       = src_valid & read;    // read is the sink's ready
  assign src_sop   = head.sop;
  assign src_eop   = head.eop;

  // streams are network order so symbol 0 of memory becomes the top symbol
  for (genvar i = 0; i < symbols; i++)
  begin : g_reverse
    assign src_data[i*`RM_SYMBOL_W +: `RM_SYMBOL_W] =
        head.data[`RM_DATA_W - (i+1)*`RM_SYMBOL_W +: `RM_SYMBOL_W];
  end

  always_ff @(posedge clk)
  begin
    if (write)
      entries[write_ptr] <= write_entry;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      write_ptr <= '0;
      read_ptr  <= '0;
      used      <= '0;
    end
    else
    begin
      if (write)
        write_ptr <= write_ptr + 1'b1;   // depth is a power of two so the pointers just wrap
      if (pop)
        read_ptr <= read_ptr + 1'b1;
      case ({write, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;           // both or neither leave the level alone
      endcase
    end
  end

endmodule

// File: hw/read_master.sv
// one descriptor at a time, the next is taken only after its response is popped
// full aligned words only, byteenable is always all ones
`include "read_master_params.svh"

module read_master (
  input  logic                            clk,
  input  logic                            reset,
  input  read_master_pkg::descriptor_t    command,
  input  logic                            command_valid,
  output logic                            command_ready,
  output read_master_pkg::response_t      response,
  output logic                            response_valid,
  input  logic                            response_ready,
  input  logic                            stop,
  output logic [`RM_ADDR_W-1:0]           mem_address,
  output logic                            mem_read,
  output logic [`RM_BURST_W-1:0]          mem_burstcount,
  output logic [`RM_BYTES-1:0]            mem_byteenable,
  input  logic [`RM_DATA_W-1:0]           mem_readdata,
  input  logic                            mem_waitrequest,
  input  logic                            mem_readdatavalid,
  output logic [`RM_DATA_W-1:0]           src_data,
  output logic                            src_sop,
  output logic                            src_eop,
  output logic                            src_valid,
  input  logic                            src_ready
);

  logic                             go;
  logic                             response_pop;
  logic                             generate_sop_q;
  logic                             generate_eop_q;
  logic                             read_accepted;
  logic                             issue_done;
  logic                             stopped;
  logic                             throttle;
  logic                             first_word;
  logic                             last_word;
  logic                             all_returned;
  logic [`RM_FIFO_DEPTH_LOG2:0]     fifo_used;
  read_master_pkg::fifo_entry_t     fifo_entry;

  assign go             = command_valid & command_ready;
  assign response_pop   = response_valid & response_ready;
  assign mem_byteenable = '1;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      command_ready  <= 1'b1;   // ready for a command straight out of reset
      response_valid <= 1'b0;
      response       <= '0;
      generate_sop_q <= 1'b0;
      generate_eop_q <= 1'b0;
    end
    else
    begin
      if (go)
        command_ready <= 1'b0;
      else if (response_pop)
        command_ready <= 1'b1;
      if (go)
      begin
        generate_sop_q <= command.generate_sop;
        generate_eop_q <= command.generate_eop;
      end
      // response payload is frozen from its rise until the pop
      if (all_returned)
      begin
        response_valid   <= 1'b1;
        response.done    <= 1'b1;
        response.stopped <= stopped;
      end
      else if (response_pop)
      begin
        response_valid <= 1'b0;
        response       <= '0;
      end
    end
  end

  // the command flags decide whether the first and last words carry packet marks
  always_comb
  begin
    fifo_entry.data = mem_readdata;
    fifo_entry.sop  = first_word & generate_sop_q;
    fifo_entry.eop  = last_word & generate_eop_q;
  end

  read_issue u_read_issue (
    .clk             (clk),
    .reset           (reset),
    .go              (go),
    .start_address   (command.address),
    .length          (command.length),
    .throttle        (throttle),
    .stop            (stop),
    .mem_waitrequest (mem_waitrequest),
    .mem_address     (mem_address),
    .mem_read        (mem_read),
    .mem_burstcount  (mem_burstcount),
    .read_accepted   (read_accepted),
    .issue_done      (issue_done),
    .stopped         (stopped)
  );

  pending_reads u_pending_reads (
    .clk               (clk),
    .reset             (reset),
    .go                (go),
    .read_accepted     (read_accepted),
    .mem_burstcount    (mem_burstcount),
    .mem_readdatavalid (mem_readdatavalid),
    .fifo_used         (fifo_used),
    .issue_done        (issue_done),
    .first_word        (first_word),
    .last_word         (last_word),
    .throttle          (throttle),
    .all_returned      (all_returned)
  );

  stream_fifo u_stream_fifo (
    .clk         (clk),
    .reset       (reset),
    .write       (mem_readdatavalid),   // never refused, the throttle keeps room for it
    .write_entry (fifo_entry),
    .read        (src_ready),
    .src_data    (src_data),
    .src_sop     (src_sop),
    .src_eop     (src_eop),
    .src_valid   (src_valid),
    .used        (fifo_used)
  );

endmodule

// File: tb/read_master_assertions.sv
// memory words are assumed to be word address ^ 32'h5a5a_0000 and symbols are bytes of a 32-bit word
// the stream must drain before each response is popped
`include "read_master_params.svh"

module read_master_assertions (
  input logic                          clk,
  input logic                          reset,
  input read_master_pkg::descriptor_t  command,
  input logic                          command_valid,
  input logic                          command_ready,
  input read_master_pkg::response_t    response,
  input logic                          response_valid,
  input logic                          response_ready,
  input logic                          stop,
  input logic [`RM_ADDR_W-1:0]         mem_address,
  input logic                          mem_read,
  input logic [`RM_BURST_W-1:0]        mem_burstcount,
  input logic [`RM_BYTES-1:0]          mem_byteenable,
  input logic                          mem_waitrequest,
  input logic                          mem_readdatavalid,
  input logic [`RM_DATA_W-1:0]         src_data,
  input logic                          src_sop,
  input logic                          src_eop,
  input logic                          src_valid,
  input logic                          src_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned           error_count = 0;   // the testbench top watches this
  int unsigned           words_expected;    // whole words in the current command
  int unsigned           words_to_request;  // words not yet covered by an accepted burst
  int unsigned           returns_seen;
  int unsigned           beats_seen;
  logic [`RM_ADDR_W-1:0] beat_address;      // byte address the next beat must come from
  logic                  sop_wanted;
  logic                  eop_wanted;
  logic                  go;
  logic                  beat;
  logic [`RM_DATA_W-1:0] memory_word;
  logic [`RM_DATA_W-1:0] expected_data;

  assign go          = command_valid & command_ready;
  assign beat        = src_valid & src_ready;
  assign memory_word = (beat_address >> `RM_BYTES_LOG2) ^ 32'h5a5a_0000;
  // the lowest memory byte has to leave in the top symbol
  assign expected_data = {memory_word[7:0], memory_word[15:8], memory_word[23:16],
      memory_word[31:24]};

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      words_expected   <= 0;
      words_to_request <= 0;
      returns_seen     <= 0;
      beats_seen       <= 0;
      beat_address     <= '0;
      sop_wanted       <= 1'b0;
      eop_wanted       <= 1'b0;
    end
    else if (go)
    begin
      words_expected   <= command.length >> `RM_BYTES_LOG2;
      words_to_request <= command.length >> `RM_BYTES_LOG2;
      returns_seen     <= 0;
      beats_seen       <= 0;
      beat_address     <= command.address;   // beats count up from here
      sop_wanted       <= command.generate_sop;
      eop_wanted       <= command.generate_eop;
    end
    else
    begin
      if (mem_read && !mem_waitrequest)
        words_to_request <= words_to_request - mem_burstcount;
      if (mem_readdatavalid)
        returns_seen <= returns_seen + 1;
      if (beat)
      begin
        beats_seen   <= beats_seen + 1;
        beat_address <= beat_address + `RM_BYTES;
      end
    end
  end

  a_beat_data: assert property (@(posedge clk) disable iff (reset)
      beat |-> src_data == expected_data)
  else
  begin
    error_count++;
    $error("** Error %0t: beat %h, expected %h", $time, $sampled(src_data),
        $sampled(expected_data));
  end

  a_beat_marks: assert property (@(posedge clk) disable iff (reset)
      beat |-> src_sop == (sop_wanted && beats_seen == 0)
          && src_eop == (eop_wanted && beats_seen == words_expected - 1))
  else
  begin
    error_count++;
    $error("** Error %0t: sop %b eop %b on beat %0d of %0d", $time, $sampled(src_sop),
        $sampled(src_eop), beats_seen, words_expected);
  end

  // every beat of the command has left the stream by the time its response is popped
  a_beat_total: assert property (@(posedge clk) disable iff (reset)
      response_valid && response_ready |-> beats_seen == words_expected)
  else
  begin
    error_count++;
    $error("** Error %0t: %0d beats streamed, expected %0d", $time, beats_seen,
        words_expected);
  end

  a_burst_legal: assert property (@(posedge clk) disable iff (reset)
      mem_read |-> mem_burstcount >= 1 && mem_burstcount <= `RM_MAX_BURST
          && mem_burstcount <= words_to_request
          && mem_address[`RM_BYTES_LOG2 +: `RM_BURST_W-1] + mem_burstcount <= `RM_MAX_BURST)
  else
  begin
    error_count++;
    $error("** Error %0t: burst of %0d at %h with %0d words left", $time,
        $sampled(mem_burstcount), $sampled(mem_address), words_to_request);
  end

  a_burst_hold: assert property (@(posedge clk) disable iff (reset)
      mem_read && mem_waitrequest |=> mem_read && $stable(mem_address)
          && $stable(mem_burstcount))
  else
  begin
    error_count++;
    $error("** Error %0t: read request changed under waitrequest", $time);
  end

  // only whole words are ever read
  a_byteenable: assert property (@(posedge clk) disable iff (reset)
      mem_read |-> mem_byteenable == {`RM_BYTES{1'b1}})
  else
  begin
    error_count++;
    $error("** Error %0t: byteenable %b, expected all ones", $time,
        $sampled(mem_byteenable));
  end

  a_response: assert property (@(posedge clk) disable iff (reset)
      $rose(response_valid) |-> response.done && returns_seen == words_expected
          && response.stopped == $past(stop))
  else
  begin
    error_count++;
    $error("** Error %0t: response %b after %0d returns, expected %0d", $time,
        $sampled(response), returns_seen, words_expected);
  end

  a_command_held: assert property (@(posedge clk) disable iff (reset)
      (go || !command_ready) && !(response_valid && response_ready) |=> !command_ready)
  else
  begin
    error_count++;
    $error("** Error %0t: command_ready rose before the pop", $time);
  end

  a_stop_holds: assert property (@(posedge clk) disable iff (reset)
      stop && (!mem_read || !mem_waitrequest) |=> !mem_read)
  else
  begin
    error_count++;
    $error("** Error %0t: read requested while stopped", $time);
  end

  a_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> command_ready && !mem_read && !response_valid && !src_valid)
  else
  begin
    error_count++;
    $error("** Error %0t: outputs wrong after reset", $time);
  end

endmodule

bind read_master read_master_assertions checks (.*);

// File: tb/read_master_tb.sv
// drives 12 descriptors into read_master against an in-order memory model with random latency
// all checking sits in the bound assertion module, this top only turns its verdict into a result
`include "read_master_params.svh"

module read_master_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 12 * 20 * 20 + 200;

  logic                          clk = 1'b0;
  logic                          reset = 1'b1;
  read_master_pkg::descriptor_t  command = '0;
  logic                          command_valid = 1'b0;
  logic                          command_ready;
  read_master_pkg::response_t    response;
  logic                          response_valid;
  logic                          response_ready = 1'b0;
  logic                          stop = 1'b0;
  logic [`RM_ADDR_W-1:0]         mem_address;
  logic                          mem_read;
  logic [`RM_BURST_W-1:0]        mem_burstcount;
  logic [`RM_BYTES-1:0]          mem_byteenable;
  logic [`RM_DATA_W-1:0]         mem_readdata = '0;
  logic                          mem_waitrequest = 1'b1;
  logic                          mem_readdatavalid = 1'b0;
  logic [`RM_DATA_W-1:0]         src_data;
  logic                          src_sop;
  logic                          src_eop;
  logic                          src_valid;
  logic                          src_ready = 1'b0;

  logic [31:0]                   lfsr_state = 32'ha68c_cc71;
  logic [`RM_ADDR_W-1:0]         pending_words [$];   // byte addresses still owed by the memory
  int unsigned                   return_delay = 0;
  int unsigned                   cycle_count;

  read_master uut (.*);

  always #4 clk = ~clk;   // 8 ns period

  // galois LFSR, one step per bit handed out
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return value;
  endfunction

  // every memory word holds its own word address under a fixed mask
  function automatic logic [`RM_DATA_W-1:0] word_value(input logic [`RM_ADDR_W-1:0] address);
    return (address >> `RM_BYTES_LOG2) ^ 32'h5a5a_0000;
  endfunction

  task automatic report_failure(input string reason);
    $display("tests failed");
    $fatal(1, "%s", reason);
  endtask

  // memory model and the random ready and stop levels, all stepped in one fixed order
  always @(posedge clk)
  begin
    mem_waitrequest <= (random_bits(2) == 0);
    src_ready       <= (random_bits(2) != 0);   // sink takes about three beats in four
    if (random_bits(3) == 0)
      stop <= ~stop;
    if (mem_read && !mem_waitrequest)
    begin
      for (int i = 0; i < mem_burstcount; i++)
        pending_words.push_back(mem_address + i * `RM_BYTES);
    end
    mem_readdatavalid <= 1'b0;
    if (pending_words.size() != 0)
    begin
      if (return_delay == 0)
      begin
        mem_readdata      <= word_value(pending_words.pop_front());
        mem_readdatavalid <= 1'b1;
        return_delay = random_bits(2);   // gap before the next word, 0 to 3 cycles
      end
      else
        return_delay--;
    end
  end

  // offers one descriptor, then pops its response once the stream has drained
  task automatic run_command(input logic [`RM_ADDR_W-1:0] address, input int words,
                             input logic sop, input logic eop);
    command.address      <= address;
    command.length       <= `RM_LEN_W'(words * `RM_BYTES);
    command.generate_sop <= sop;
    command.generate_eop <= eop;
    command_valid        <= 1'b1;
    @(posedge clk);
    while (!command_ready)
      @(posedge clk);
    command_valid <= 1'b0;
    while (!response_valid)
      @(posedge clk);
    while (src_valid)
      @(posedge clk);
    response_ready <= 1'b1;
    @(posedge clk);
    response_ready <= 1'b0;
  endtask

  initial
  begin
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    run_command(32'h0000_1000, 1, 1'b1, 1'b1);
    run_command(32'h0000_2004, 20, 1'b1, 1'b0);   // starts one word past a burst boundary
    run_command(32'h0000_3008, 7, 1'b0, 1'b1);
    run_command(32'h0000_400c, 4, 1'b0, 1'b0);
    run_command(32'h0000_5000, 16, 1'b1, 1'b1);
    run_command(32'h0000_6014, 3, 1'b1, 1'b0);
    run_command(32'h0001_0ff8, 13, 0, 1'b1);      // crosses a 4 KiB page
    run_command(32'h0000_7000, 2, 1'b0, 1'b0);
    run_command(32'h0000_8004, 19, 1'b1, 1'b1);
    run_command(32'h0000_900c, 1, 1'b0, 1'b1);
    run_command(32'h0000_a010, 9, 1'b1, 1'b0);
    run_command(32'h0002_0008, 20, 1'b0, 1'b0);
    @(posedge clk);
    if (uut.checks.error_count == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
      report_failure("assertion failures were reported");
  end

  initial
  begin
    wait (uut.checks.error_count != 0);
    report_failure("an assertion on the read master failed");
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    report_failure("the run did not finish within the cycle limit");
  end

endmodule

// File: files.f
+incdir+common
common/read_master_pkg.sv
hw/read_issue.sv
hw/pending_reads.sv
hw/stream_fifo.sv
hw/read_master.sv
tb/read_master_assertions.sv
tb/read_master_tb.sv
